// File: pmu_ahb.f
hw/pmu_pkg.sv
hw/pmu_ahb_front.sv
hw/pmu_counter_bank.sv
hw/pmu_read_mux.sv
hw/pmu_ahb_top.sv
dv/pmu_ahb_properties.sv
dv/pmu_ahb_tb.sv

// File: Makefile
TOP := pmu_ahb_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f pmu_ahb.f -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@grep -q "Test OK" sim.log
	@! grep -q "Test FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/pmu_ahb_tb.sv
// Directed tests for N_COUNTERS of 4; single NONSEQ transfers only, run bounded by 2000 cycles
`timescale 1ns/100ps

module pmu_ahb_tb import pmu_pkg::*; ();

    localparam int N_CNT      = 4;
    localparam int MAX_CYCLES = 2000;
    // Map after the counters
    localparam reg_idx_t IDX_STATUS   = reg_idx_t'(N_CNT + 1);
    localparam reg_idx_t IDX_MASK     = reg_idx_t'(N_CNT + 2);
    localparam reg_idx_t IDX_UNMAPPED = reg_idx_t'(N_CNT + 3);
    localparam reg_word_t CFG_EN  = reg_word_t'(1) << CFG_EN_BIT;
    localparam reg_word_t CFG_CLR = reg_word_t'(1) << CFG_CLR_BIT;

    logic             clk_i;
    logic             rstn_i;
    logic             hsel_i;
    logic             hreadyi_i;
    haddr_t           haddr_i;
    logic             hwrite_i;
    htrans_t          htrans_i;
    reg_word_t        hwdata_i;
    logic             hreadyo_o;
    logic             hresp_o;
    reg_word_t        hrdata_o;
    logic [N_CNT-1:0] events_i;
    logic             intr_overflow_o;

    integer    seed;
    int        errors;
    int        checks;
    int        tests_run;
    int        cycles = 0;
    // Expected counter values
    reg_word_t exp_cnt [N_CNT];

    pmu_ahb_top #(
        .N_COUNTERS (N_CNT)
    ) i_pmu_ahb_top (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .hsel_i          (hsel_i),
        .hreadyi_i       (hreadyi_i),
        .haddr_i         (haddr_i),
        .hwrite_i        (hwrite_i),
        .htrans_i        (htrans_i),
        .hwdata_i        (hwdata_i),
        .hreadyo_o       (hreadyo_o),
        .hresp_o         (hresp_o),
        .hrdata_o        (hrdata_o),
        .events_i        (events_i),
        .intr_overflow_o (intr_overflow_o)
    );

    bind pmu_ahb_top pmu_ahb_properties i_props (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .hsel_i          (hsel_i),
        .hreadyi_i       (hreadyi_i),
        .hwrite_i        (hwrite_i),
        .htrans_i        (htrans_i),
        .hrdata_o        (hrdata_o),
        .hreadyo_o       (hreadyo_o),
        .hresp_o         (hresp_o),
        .intr_overflow_o (intr_overflow_o)
    );

    // 8 ns period
    always #4 clk_i = ~clk_i;

    // Hang guard
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // ------------------------------------------------
    // Compare tasks
    // ------------------------------------------------

    task automatic check_word(input string name, input reg_word_t got, input reg_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // ------------------------------------------------
    // Bus tasks entered and left 1 ns after a rising edge
    // ------------------------------------------------

    function automatic reg_idx_t cnt_idx(input int i);
        return reg_idx_t'(REG_CNT_BASE + i);
    endfunction

    task automatic ahb_write(input reg_idx_t idx, input reg_word_t data);
        // Address phase
        hsel_i   = 1'b1;
        htrans_i = NONSEQ;
        hwrite_i = 1'b1;
        haddr_i  = haddr_t'(idx) << 2;
        @(posedge clk_i);
        #1;
        // Data phase, zero wait states
        hsel_i   = 1'b0;
        htrans_i = IDLE;
        hwrite_i = 1'b0;
        hwdata_i = data;
        check_bit("hreadyo_o", hreadyo_o, 1'b1);
        check_bit("hresp_o", hresp_o, 1'b0);
        // Stored at this edge
        @(posedge clk_i);
        #1;
    endtask

    task automatic ahb_read(input reg_idx_t idx, output reg_word_t data);
        hsel_i   = 1'b1;
        htrans_i = NONSEQ;
        hwrite_i = 1'b0;
        haddr_i  = haddr_t'(idx) << 2;
        @(posedge clk_i);
        #1;
        hsel_i   = 1'b0;
        htrans_i = IDLE;
        check_bit("hreadyo_o", hreadyo_o, 1'b1);
        data = hrdata_o;
        check_bit("hresp_o", hresp_o, 1'b0);
        @(posedge clk_i);
        #1;
    endtask

    // One count per edge while high
    task automatic pulse_event(input int idx, input int n);
        events_i[idx] = 1'b1;
        repeat (n) @(posedge clk_i);
        #1;
        events_i[idx] = 1'b0;
    endtask

    task automatic check_counters();
        reg_word_t rd;
        for (int i = 0; i < N_CNT; i++) begin
            ahb_read(cnt_idx(i), rd);
            check_word($sformatf("counter%0d", i), rd, exp_cnt[i]);
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        tests_run++;
        $display("%s finished with %0d errors", name, errors - err0);
    endtask

    // ------------------------------------------------
    // Tests
    // ------------------------------------------------

    task automatic test_reset_values();
        int        err0;
        reg_word_t rd;
        err0 = errors;
        ahb_read(REG_CFG, rd);
        check_word("cfg", rd, '0);
        check_counters();
        ahb_read(IDX_STATUS, rd);
        check_word("status", rd, '0);
        ahb_read(IDX_MASK, rd);
        check_word("mask", rd, '0);
        check_bit("intr_overflow_o", intr_overflow_o, 1'b0);
        finish_test("reset_values", err0);
    endtask

    task automatic test_register_rw();
        int        err0;
        reg_word_t wr;
        reg_word_t rd;
        err0 = errors;
        wr = reg_word_t'($random(seed));
        ahb_write(REG_CFG, wr);
        ahb_read(REG_CFG, rd);
        check_word("cfg", rd, wr);
        ahb_write(REG_CFG, '0);
        wr = reg_word_t'($random(seed));
        ahb_write(IDX_MASK, wr);
        ahb_read(IDX_MASK, rd);
        check_word("mask", rd, wr);
        // Status is clear, so any mask keeps the line low
        check_bit("intr_overflow_o", intr_overflow_o, 1'b0);
        ahb_write(IDX_MASK, '0);
        // Unmapped writes are dropped
        ahb_write(IDX_UNMAPPED, reg_word_t'($random(seed)));
        ahb_read(IDX_UNMAPPED, rd);
        check_word("unmapped", rd, '0);
        ahb_read(8'hff, rd);
        check_word("unmapped_ff", rd, '0);
        check_counters();
        finish_test("register_rw", err0);
    endtask

    task automatic test_event_counting();
        int err0;
        int n;
        err0 = errors;
        ahb_write(REG_CFG, CFG_EN);
        for (int i = 0; i < N_CNT; i++) begin
            n = 2 + 3 * i;
            pulse_event(i, n);
            exp_cnt[i] = exp_cnt[i] + reg_word_t'(n);
            check_counters();
        end
        // Nothing moves while disabled
        ahb_write(REG_CFG, '0);
        pulse_event(0, 5);
        pulse_event(3, 2);
        check_counters();
        finish_test("event_counting", err0);
    endtask

    task automatic test_clear();
        int        err0;
        reg_word_t rd;
        err0 = errors;
        ahb_write(REG_CFG, CFG_EN);
        // Overflow counter 0 so status has something to clear
        ahb_write(cnt_idx(0), '1);
        pulse_event(0, 1);
        exp_cnt[0] = '0;
        ahb_read(IDX_STATUS, rd);
        check_word("status", rd, 32'h1);
        ahb_write(REG_CFG, CFG_EN | CFG_CLR);
        for (int i = 0; i < N_CNT; i++) begin
            exp_cnt[i] = '0;
        end
        // Held at zero even with an event
        pulse_event(1, 3);
        check_counters();
        ahb_read(IDX_STATUS, rd);
        check_word("status", rd, '0);
        // Resume from zero
        ahb_write(REG_CFG, CFG_EN);
        pulse_event(2, 4);
        exp_cnt[2] = 32'd4;
        check_counters();
        finish_test("clear", err0);
    endtask

    task automatic test_overflow();
        int        err0;
        reg_word_t rd;
        err0 = errors;
        ahb_write(REG_CFG, CFG_EN);
        ahb_write(cnt_idx(3), '1);
        pulse_event(3, 1);
        exp_cnt[3] = '0;
        ahb_read(cnt_idx(3), rd);
        check_word("counter3", rd, '0);
        ahb_read(IDX_STATUS, rd);
        check_word("status", rd, 32'h8);
        check_bit("intr_overflow_o", intr_overflow_o, 1'b0);
        // Unmasking another bit keeps it low
        ahb_write(IDX_MASK, 32'h2);
        check_bit("intr_overflow_o", intr_overflow_o, 1'b0);
        ahb_write(IDX_MASK, 32'h8);
        check_bit("intr_overflow_o", intr_overflow_o, 1'b1);
        // Write 1 to clear
        ahb_write(IDX_STATUS, 32'h8);
        ahb_read(IDX_STATUS, rd);
        check_word("status", rd, '0);
        check_bit("intr_overflow_o", intr_overflow_o, 1'b0);
        ahb_write(IDX_MASK, '0);
        finish_test("overflow", err0);
    endtask

    task automatic test_write_read_counter();
        int        err0;
        reg_word_t wr;
        reg_word_t rd;
        err0 = errors;
        ahb_write(REG_CFG, CFG_EN);
        for (int i = 0; i < N_CNT; i++) begin
            wr = reg_word_t'($random(seed));
            ahb_write(cnt_idx(i), wr);
            exp_cnt[i] = wr;
            ahb_read(cnt_idx(i), rd);
            check_word($sformatf("counter%0d", i), rd, wr);
        end
        check_counters();
        ahb_write(REG_CFG, '0);
        finish_test("write_read_counter", err0);
    endtask

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------

    initial begin
        clk_i     = 1'b0;
        rstn_i    = 1'b0;
        hsel_i    = 1'b0;
        hreadyi_i = 1'b1;
        haddr_i   = '0;
        hwrite_i  = 1'b0;
        htrans_i  = IDLE;
        hwdata_i  = '0;
        events_i  = '0;
        seed      = 26;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        for (int i = 0; i < N_CNT; i++) begin
            exp_cnt[i] = '0;
        end
        repeat (4) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        test_reset_values();
        test_register_rw();
        test_event_counting();
        test_clear();
        test_overflow();
        test_write_read_counter();

        $display("Tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: dv/pmu_ahb_properties.sv
// Port level checks for pmu_ahb_top; bound into every instance, expects one clock and no wait states
`timescale 1ns/100ps

module pmu_ahb_properties import pmu_pkg::*; (
    input logic      clk_i,
    input logic      rstn_i,
    // AHB inputs seen by the slave
    input logic      hsel_i,
    input logic      hreadyi_i,
    input logic      hwrite_i,
    input htrans_t   htrans_i,
    // Slave outputs under check
    input reg_word_t hrdata_o,
    input logic      hreadyo_o,
    input logic      hresp_o,
    input logic      intr_overflow_o
);

    // Selected read address phase in this cycle
    logic rd_addr;

    assign rd_addr = hsel_i && hreadyi_i && !hwrite_i
                     && ((htrans_i == NONSEQ) || (htrans_i == SEQ));

    // ------------------------------------------------
    // Response and read data
    // ------------------------------------------------

    // Zero wait states, OKAY only
    resp_okay: assert property (@(posedge clk_i) disable iff (!rstn_i)
        hreadyo_o && !hresp_o)
        else $error("hreadyo_o low or hresp_o not OKAY");

    // No read address phase last cycle means an empty data bus now
    rdata_idle_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$past(rd_addr) |-> (hrdata_o == '0))
        else $error("hrdata_o nonzero without a read data phase");

    // Interrupt starts low once reset is released
    intr_low_after_reset: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> !intr_overflow_o)
        else $error("intr_overflow_o high right after reset");

endmodule

// File: hw/pmu_ahb_top.sv
// N_COUNTERS from 1 to 32; hsize, hburst, hprot and hmastlock are not ports
`timescale 1ns/100ps

module pmu_ahb_top import pmu_pkg::*; #(
    parameter int unsigned N_COUNTERS = 4
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    // AHB-lite slave
    input  logic                  hsel_i,
    input  logic                  hreadyi_i,
    input  haddr_t                haddr_i,
    input  logic                  hwrite_i,
    input  htrans_t               htrans_i,
    input  reg_word_t             hwdata_i,
    output logic                  hreadyo_o,
    output logic                  hresp_o,
    output reg_word_t             hrdata_o,
    // Event lines, one per counter
    input  logic [N_COUNTERS-1:0] events_i,
    // Overflow interrupt level
    output logic                  intr_overflow_o
);

    // Data phase request to bank and read side
    ahb_req_t                   req;
    // Register contents to the read side
    reg_word_t                  cfg;
    reg_word_t [N_COUNTERS-1:0] counters;
    reg_word_t                  status;
    reg_word_t                  mask;

    // ------------------------------------------------
    // Address phase capture
    // ------------------------------------------------

    pmu_ahb_front i_front (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .hsel_i    (hsel_i),
        .hreadyi_i (hreadyi_i),
        .haddr_i   (haddr_i),
        .hwrite_i  (hwrite_i),
        .htrans_i  (htrans_i),
        .req_o     (req)
    );

    // Registers and counters
    pmu_counter_bank #(
        .N_COUNTERS (N_COUNTERS)
    ) i_bank (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .req_i           (req),
        .hwdata_i        (hwdata_i),
        .events_i        (events_i),
        .cfg_o           (cfg),
        .counters_o      (counters),
        .status_o        (status),
        .mask_o          (mask),
        .intr_overflow_o (intr_overflow_o)
    );

    // Read data and response
    pmu_read_mux #(
        .N_COUNTERS (N_COUNTERS)
    ) i_read_mux (
        .req_i      (req),
        .cfg_i      (cfg),
        .counters_i (counters),
        .status_i   (status),
        .mask_i     (mask),
        .hrdata_o   (hrdata_o),
        .hreadyo_o  (hreadyo_o),
        .hresp_o    (hresp_o)
    );

endmodule

// File: hw/pmu_read_mux.sv
// Zero wait state slave; unmapped indices and non-read phases return zero
`timescale 1ns/100ps

module pmu_read_mux import pmu_pkg::*; #(
    parameter int unsigned N_COUNTERS = 4
) (
    // Data phase request
    input  ahb_req_t                   req_i,
    // Register contents
    input  reg_word_t                  cfg_i,
    input  reg_word_t [N_COUNTERS-1:0] counters_i,
    input  reg_word_t                  status_i,
    input  reg_word_t                  mask_i,
    // AHB data phase outputs
    output reg_word_t                  hrdata_o,
    output logic                       hreadyo_o,
    output logic                       hresp_o
);

    // Same map as the counter bank
    localparam reg_idx_t REG_STATUS = reg_idx_t'(N_COUNTERS + 1);
    localparam reg_idx_t REG_MASK   = reg_idx_t'(N_COUNTERS + 2);

    // Single bit response, OKAY only
    localparam logic HRESP_OKAY = 1'b0;

    // ------------------------------------------------
    // Read data select
    // ------------------------------------------------

    // Map indices never overlap, so the order below does not matter
    always_comb begin
        hrdata_o = '0;
        if (req_i.read_en) begin
            if (req_i.reg_idx == REG_CFG) begin
                hrdata_o = cfg_i;
            end
            if (req_i.reg_idx == REG_STATUS) begin
                hrdata_o = status_i;
            end
            if (req_i.reg_idx == REG_MASK) begin
                hrdata_o = mask_i;
            end
            for (int i = 0; i < N_COUNTERS; i++) begin
                if (req_i.reg_idx == reg_idx_t'(REG_CNT_BASE + i)) begin
                    hrdata_o = counters_i[i];
                end
            end
        end
    end

    // ------------------------------------------------
    // Response
    // ------------------------------------------------

    // Every transfer completes in its first data cycle
    assign hreadyo_o = 1'b1;
    assign hresp_o   = HRESP_OKAY;

endmodule

// File: hw/pmu_counter_bank.sv
// Counter i counts event i; counters wrap silently apart from the sticky status bit
`timescale 1ns/100ps

module pmu_counter_bank import pmu_pkg::*; #(
    parameter int unsigned N_COUNTERS = 4
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    // Data phase request and write data
    input  ahb_req_t                   req_i,
    input  reg_word_t                  hwdata_i,
    // One event line per counter
    input  logic [N_COUNTERS-1:0]      events_i,
    // Register contents for the read side
    output reg_word_t                  cfg_o,
    output reg_word_t [N_COUNTERS-1:0] counters_o,
    output reg_word_t                  status_o,
    output reg_word_t                  mask_o,
    // Level interrupt
    output logic                       intr_overflow_o
);

    // Status and mask follow the last counter
    localparam reg_idx_t REG_STATUS = reg_idx_t'(N_COUNTERS + 1);
    localparam reg_idx_t REG_MASK   = reg_idx_t'(N_COUNTERS + 2);

    reg_word_t                  cfg_q;
    reg_word_t                  mask_q;
    reg_word_t                  status_q;
    reg_word_t                  status_d;
    reg_word_t [N_COUNTERS-1:0] cnt_q;
    reg_word_t [N_COUNTERS-1:0] cnt_d;
    // Counters that overflow this cycle
    logic [N_COUNTERS-1:0]      ovf_set;
    logic [N_COUNTERS-1:0]      cnt_wr;
    logic                       wr_cfg;
    logic                       wr_status;
    logic                       wr_mask;
    logic                       clr;
    logic                       count_en;

    // ------------------------------------------------
    // Write decode
    // ------------------------------------------------

    assign wr_cfg    = req_i.write_en && (req_i.reg_idx == REG_CFG);
    assign wr_status = req_i.write_en && (req_i.reg_idx == REG_STATUS);
    assign wr_mask   = req_i.write_en && (req_i.reg_idx == REG_MASK);

    always_comb begin
        for (int i = 0; i < N_COUNTERS; i++) begin
            cnt_wr[i] = req_i.write_en && (req_i.reg_idx == reg_idx_t'(REG_CNT_BASE + i));
        end
    end

    // Control bits come from the stored configuration
    assign clr      = cfg_q[CFG_CLR_BIT];
    assign count_en = cfg_q[CFG_EN_BIT];

    // ------------------------------------------------
    // Counters
    // ------------------------------------------------

    // Clear beats a bus write, a bus write beats an increment
    always_comb begin
        cnt_d   = cnt_q;
        ovf_set = '0;
        for (int i = 0; i < N_COUNTERS; i++) begin
            if (clr) begin
                cnt_d[i] = '0;
            end else if (cnt_wr[i]) begin
                cnt_d[i] = hwdata_i;
            end else if (count_en && events_i[i]) begin
                // All ones wraps to zero and flags the overflow
                cnt_d[i]   = cnt_q[i] + 32'd1;
                ovf_set[i] = (cnt_q[i] == '1);
            end
        end
    end

    // ------------------------------------------------
    // Overflow status
    // ------------------------------------------------

    // Write 1 to clear, a new overflow on the same bit wins
    always_comb begin
        status_d = status_q;
        if (wr_status) begin
            status_d = status_q & ~hwdata_i;
        end
        status_d = status_d | reg_word_t'(ovf_set);
        if (clr) begin
            status_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cfg_q    <= '0;
            mask_q   <= '0;
            status_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (wr_cfg) begin
                cfg_q <= hwdata_i;
            end
            if (wr_mask) begin
                mask_q <= hwdata_i;
            end
            status_q <= status_d;
            cnt_q    <= cnt_d;
        end
    end

    // Any unmasked sticky overflow raises the interrupt
    assign intr_overflow_o = |(status_q & mask_q);

    assign cfg_o      = cfg_q;
    assign counters_o = cnt_q;
    assign status_o   = status_q;
    assign mask_o     = mask_q;

endmodule

// File: hw/pmu_ahb_front.sv
// Assumes word aligned accesses; hsize, hburst and hprot are not looked at
`timescale 1ns/100ps

module pmu_ahb_front import pmu_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    // AHB address phase
    input  logic     hsel_i,
    input  logic     hreadyi_i,
    input  haddr_t   haddr_i,
    input  logic     hwrite_i,
    input  htrans_t  htrans_i,
    // Data phase request
    output ahb_req_t req_o
);

    // Transfer state of the pending data phase
    htrans_t  state_q;
    htrans_t  state_d;
    // Address phase accepted this cycle
    logic     addr_taken;
    // Data phase of an accepted transfer
    logic     data_active;
    // Registered address phase payload
    logic     write_q;
    reg_idx_t idx_q;

    // ------------------------------------------------
    // Address phase
    // ------------------------------------------------

    // Deselected or not-ready phases are treated as IDLE
    always_comb begin
        case (htrans_i)
            BUSY, NONSEQ, SEQ: state_d = (hsel_i && hreadyi_i) ? htrans_i : IDLE;
            default:           state_d = IDLE;
        endcase
    end

    // Only NONSEQ and SEQ carry a real access
    assign addr_taken = (state_d == NONSEQ) || (state_d == SEQ);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Direction and word index load only on an accepted phase
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            write_q <= 1'b0;
            idx_q   <= '0;
        end else if (addr_taken) begin
            write_q <= hwrite_i;
            idx_q   <= haddr_i[REG_IDX_W+1:2];
        end
    end

    // ------------------------------------------------
    // Data phase
    // ------------------------------------------------

    assign data_active = (state_q == NONSEQ) || (state_q == SEQ);

    // IDLE and BUSY give an inactive request
    always_comb begin
        req_o.write_en = data_active && write_q;
        req_o.read_en  = data_active && !write_q;
        req_o.reg_idx  = idx_q;
    end

endmodule

// File: hw/pmu_pkg.sv
// Register map is word addressed from haddr bit 2, at most 32 counters, hresp is a single bit
package pmu_pkg;

    // ------------------------------------------------
    // Widths
    // ------------------------------------------------

    // One register or bus data word
    typedef logic [31:0] reg_word_t;

    // AHB address
    typedef logic [31:0] haddr_t;

    // Register index width, taken from haddr starting at bit 2
    localparam int unsigned REG_IDX_W = 8;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // ------------------------------------------------
    // Register map
    // ------------------------------------------------

    // Configuration register
    localparam reg_idx_t REG_CFG = 8'd0;
    // Enable counting
    localparam int unsigned CFG_EN_BIT = 0;
    // Hold counters and status at zero while set
    localparam int unsigned CFG_CLR_BIT = 1;

    // First counter, counter i sits at REG_CNT_BASE + i
    localparam reg_idx_t REG_CNT_BASE = 8'd1;

    // Status and mask are one word each, so this bounds the counter count
    // Status sits at N_COUNTERS + 1, mask at N_COUNTERS + 2
    localparam int unsigned MAX_COUNTERS = 32;

    // ------------------------------------------------
    // Bus types
    // ------------------------------------------------

    // AHB transfer types, also the front end state encoding
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // Data phase request built from a registered address phase
    typedef struct packed {
        logic     write_en;
        logic     read_en;
        reg_idx_t reg_idx;
    } ahb_req_t;

endpackage
